/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_csr_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/csr_access.sv */
/*
 * CSR access decode: read data merge, legality check,
 * write strobe and write word for set and clear
 */
`default_nettype none

module csr_access (
  input  csr_addr_pkg::csr_req_t         csr_req_i,
  input  csr_regs_pkg::priv_lvl_e        priv_lvl_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] trap_rdata_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] perf_rdata_i,
  input  logic                           trap_hit_i,
  input  logic                           perf_hit_i,
  output logic                           csr_we_o,
  output logic [csr_addr_pkg::CSR_W-1:0] csr_wdata_o,
  output logic [csr_addr_pkg::CSR_W-1:0] csr_rdata_o,
  output logic                           illegal_o
);

  import csr_addr_pkg::*;

  logic wreq;      // op modifies the CSR
  logic no_hit;
  logic priv_low;
  logic ro_write;

  // at most one block claims an address
  assign csr_rdata_o = trap_hit_i ? trap_rdata_i :
                       perf_hit_i ? perf_rdata_i : '0;

  always_comb begin
    wreq = 1'b1;
    case (csr_req_i.op)
      CSR_OP_WRITE: csr_wdata_o = csr_req_i.wdata;
      CSR_OP_SET:   csr_wdata_o = csr_req_i.wdata | csr_rdata_o;
      CSR_OP_CLEAR: csr_wdata_o = ~csr_req_i.wdata & csr_rdata_o;
      default: begin  // read
        csr_wdata_o = csr_req_i.wdata;
        wreq        = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // legality
  ////////////////////////////////////////////////////////////////////

  assign no_hit   = ~(trap_hit_i | perf_hit_i);
  assign priv_low = csr_req_i.addr.fld.priv > priv_lvl_i;
  assign ro_write = (csr_req_i.addr.fld.acc == CSR_ACC_RO) & wreq;

  assign illegal_o = csr_req_i.access & (no_hit | priv_low | ro_write);

  // the access strobe is the single write cycle
  assign csr_we_o = csr_req_i.access & wreq & ~illegal_o;

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  // hit flags come from two separate decoders, so check once settled
  always_comb begin
    if (csr_req_i.access) begin
      op_known_a: assert final (!$isunknown(csr_req_i.op))
        else $error("csr op unknown during access");
    end
    one_hit_a: assert final (!(trap_hit_i && perf_hit_i))
      else $error("trap and perf blocks both claim address %h", csr_req_i.addr);
  end

endmodule

`default_nettype wire

/* hw/csr_addr_pkg.sv */
/*
 * CSR address space: implemented CSR numbers, access operations,
 * the address word with its two decode views, and the access request
 */
`default_nettype none

package csr_addr_pkg;

  localparam int unsigned CSR_W = 32;  // data word width

  localparam logic [1:0] CSR_ACC_RO    = 2'b11;  // access type of read-only CSRs
  localparam logic [3:0] CSR_PAGE_MCNT = 4'hb;   // machine counters, 0xb00 and up

  // implemented CSRs only
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hb00,
    CSR_MINSTRET      = 12'hb02,
    CSR_MHPMCOUNTER3  = 12'hb03,
    CSR_MHPMCOUNTER4  = 12'hb04,
    CSR_MCYCLEH       = 12'hb80,
    CSR_MINSTRETH     = 12'hb82,
    CSR_MHPMCOUNTER3H = 12'hb83,
    CSR_MHPMCOUNTER4H = 12'hb84,
    CSR_MHARTID       = 12'hf14
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // field view of the address, per the privileged spec layout
  typedef struct packed {
    logic [1:0] acc;   // 11:10 read-only when 2'b11
    logic [1:0] priv;  // 9:8 lowest level allowed
    logic       high;  // upper half of a 64-bit counter
    logic [1:0] grp;
    logic [4:0] idx;   // counter index
  } csr_fields_t;

  typedef union packed {
    csr_num_e    num;  // register select
    csr_fields_t fld;  // legality and counter decode
  } csr_addr_u;

  typedef struct packed {
    logic             access;
    csr_addr_u        addr;
    csr_op_e          op;
    logic [CSR_W-1:0] wdata;
  } csr_req_t;

endpackage

`default_nettype wire

/* hw/csr_perf_counters.sv */
/*
 * Performance counters: mcycle, minstret, load and store hpm counters,
 * and mcountinhibit
 */
`default_nettype none

module csr_perf_counters (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           csr_we_i,
  input  csr_addr_pkg::csr_addr_u        csr_addr_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] csr_wdata_i,
  input  csr_regs_pkg::perf_ev_t         perf_i,
  output logic [csr_addr_pkg::CSR_W-1:0] rdata_o,
  output logic                           hit_o
);

  import csr_addr_pkg::*;
  import csr_regs_pkg::*;

  logic [63:0] cnt_q    [5];  // slot 1 (mtime) stays zero
  logic [63:0] cnt_d    [5];
  logic [63:0] cnt_mask [5];
  logic [4:0]  incr;
  logic [4:0]  inhibit_q, inhibit_d;
  logic [2:0]  cnt_sel;
  logic        cnt_hit, inh_hit;

  // 0xb00..0xb04 and 0xb80..0xb84 except the mtime slot
  assign cnt_hit = ({csr_addr_i.fld.acc, csr_addr_i.fld.priv} == CSR_PAGE_MCNT) &&
                   (csr_addr_i.fld.grp == 2'b00) &&
                   (csr_addr_i.fld.idx < 5'd5) && (csr_addr_i.fld.idx != 5'd1);
  assign inh_hit = (csr_addr_i.num == CSR_MCOUNTINHIBIT);
  assign hit_o   = cnt_hit | inh_hit;
  assign cnt_sel = csr_addr_i.fld.idx[2:0];

  assign incr = {perf_i.store, perf_i.load, perf_i.instr_ret, 1'b0, 1'b1};

  assign cnt_mask[0] = '1;
  assign cnt_mask[1] = '0;
  assign cnt_mask[2] = '1;
  assign cnt_mask[3] = {{(64-HPM_W){1'b0}}, {HPM_W{1'b1}}};
  assign cnt_mask[4] = cnt_mask[3];

  always_comb begin
    rdata_o = '0;
    if (inh_hit) begin
      rdata_o[4:0] = inhibit_q;
    end else if (cnt_hit) begin
      rdata_o = csr_addr_i.fld.high ? cnt_q[cnt_sel][63:32] : cnt_q[cnt_sel][31:0];
    end
  end

  always_comb begin
    inhibit_d = inhibit_q;
    if (csr_we_i && inh_hit) begin
      inhibit_d = {csr_wdata_i[4:2], 1'b0, csr_wdata_i[0]};
    end
    for (int i = 0; i < 5; i++) begin
      cnt_d[i] = cnt_q[i];
      if (csr_we_i && cnt_hit && (cnt_sel == 3'(i))) begin  // write wins over count
        if (csr_addr_i.fld.high) begin
          cnt_d[i][63:32] = csr_wdata_i & cnt_mask[i][63:32];
        end else begin
          cnt_d[i][31:0] = csr_wdata_i & cnt_mask[i][31:0];
        end
      end else if (incr[i] && !inhibit_q[i]) begin
        cnt_d[i] = (cnt_q[i] + 64'd1) & cnt_mask[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
      for (int i = 0; i < 5; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      inhibit_q <= inhibit_d;
      cnt_q     <= cnt_d;
    end
  end

  hpm_width_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_q[3][63:HPM_W] == '0) && (cnt_q[4][63:HPM_W] == '0))
    else $error("hpm counter wider than HPM_W");

endmodule

`default_nettype wire

/* hw/csr_regs_pkg.sv */
/*
 * Register contents: privilege levels, mstatus and interrupt field types,
 * trap and performance event bundles, bit positions and reset values
 */
`default_nettype none

package csr_regs_pkg;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  // shared by mie and mip
  typedef struct packed {
    logic        software;
    logic        timer;
    logic        external;
    logic [14:0] fast;
  } irq_t;

  typedef struct packed {
    logic                           save_cause;
    logic [csr_addr_pkg::CSR_W-1:0] pc;
    logic [5:0]                     mcause;  // {interrupt, code}
    logic [csr_addr_pkg::CSR_W-1:0] mtval;
    logic                           mret;
  } trap_ev_t;

  typedef struct packed {
    logic instr_ret;
    logic load;
    logic store;
  } perf_ev_t;

  localparam int unsigned MTVEC_ALIGN = 8;      // base is 256-byte aligned
  localparam logic [1:0]  MTVEC_MODE  = 2'b01;  // vectored
  localparam int unsigned HPM_W       = 40;

  // mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LO   = 11;
  localparam int unsigned MSTATUS_MPP_HI   = 12;

  // mie and mip
  localparam int unsigned IRQ_MSI_BIT = 3;
  localparam int unsigned IRQ_MTI_BIT = 7;
  localparam int unsigned IRQ_MEI_BIT = 11;
  localparam int unsigned IRQ_MFI_LO  = 16;
  localparam int unsigned IRQ_MFI_HI  = 30;

  localparam mstatus_t MSTATUS_RST = '{mie: 1'b0, mpie: 1'b1, mpp: PRIV_LVL_U};

endpackage

`default_nettype wire

/* hw/csr_top.sv */
/*
 * CSR file top: access decode beside the trap and counter register blocks
 */
`default_nettype none

module csr_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  csr_addr_pkg::csr_req_t         csr_req_i,
  input  csr_regs_pkg::irq_t             irq_i,
  input  csr_regs_pkg::trap_ev_t         trap_i,
  input  csr_regs_pkg::perf_ev_t         perf_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] hart_id_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] boot_addr_i,
  input  logic                           mtvec_init_i,
  output logic [csr_addr_pkg::CSR_W-1:0] csr_rdata_o,
  output logic                           illegal_o,
  output logic                           irq_pending_o,
  output logic                           mstatus_mie_o,
  output logic [csr_addr_pkg::CSR_W-1:0] mepc_o,
  output logic [csr_addr_pkg::CSR_W-1:0] mtvec_o,
  output csr_regs_pkg::priv_lvl_e        priv_lvl_o
);

  import csr_addr_pkg::*;

  logic             csr_we;
  logic [CSR_W-1:0] csr_wdata;
  logic [CSR_W-1:0] trap_rdata, perf_rdata;
  logic             trap_hit, perf_hit;

  csr_access csr_access_inst (
    .csr_req_i    (csr_req_i),
    .priv_lvl_i   (priv_lvl_o),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .trap_hit_i   (trap_hit),
    .perf_hit_i   (perf_hit),
    .csr_we_o     (csr_we),
    .csr_wdata_o  (csr_wdata),
    .csr_rdata_o  (csr_rdata_o),
    .illegal_o    (illegal_o)
  );

  csr_trap_regs csr_trap_regs_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_req_i.addr),
    .csr_wdata_i   (csr_wdata),
    .irq_i         (irq_i),
    .trap_i        (trap_i),
    .hart_id_i     (hart_id_i),
    .boot_addr_i   (boot_addr_i),
    .mtvec_init_i  (mtvec_init_i),
    .rdata_o       (trap_rdata),
    .hit_o         (trap_hit),
    .priv_lvl_o    (priv_lvl_o),
    .mstatus_mie_o (mstatus_mie_o),
    .mepc_o        (mepc_o),
    .mtvec_o       (mtvec_o),
    .irq_pending_o (irq_pending_o)
  );

  csr_perf_counters csr_perf_counters_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we_i    (csr_we),
    .csr_addr_i  (csr_req_i.addr),
    .csr_wdata_i (csr_wdata),
    .perf_i      (perf_i),
    .rdata_o     (perf_rdata),
    .hit_o       (perf_hit)
  );

endmodule

`default_nettype wire

/* hw/csr_trap_regs.sv */
/*
 * Machine trap registers with the privilege level,
 * trap entry, mret and the pending interrupt summary
 */
`default_nettype none

module csr_trap_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           csr_we_i,
  input  csr_addr_pkg::csr_addr_u        csr_addr_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] csr_wdata_i,
  input  csr_regs_pkg::irq_t             irq_i,
  input  csr_regs_pkg::trap_ev_t         trap_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] hart_id_i,
  input  logic [csr_addr_pkg::CSR_W-1:0] boot_addr_i,
  input  logic                           mtvec_init_i,
  output logic [csr_addr_pkg::CSR_W-1:0] rdata_o,
  output logic                           hit_o,
  output csr_regs_pkg::priv_lvl_e        priv_lvl_o,
  output logic                           mstatus_mie_o,
  output logic [csr_addr_pkg::CSR_W-1:0] mepc_o,
  output logic [csr_addr_pkg::CSR_W-1:0] mtvec_o,
  output logic                           irq_pending_o
);

  import csr_addr_pkg::*;
  import csr_regs_pkg::*;

  priv_lvl_e        priv_lvl_q, priv_lvl_d;
  mstatus_t         mstatus_q, mstatus_d;
  irq_t             mie_q, mie_d;
  irq_t             mip;
  logic [CSR_W-1:0] mscratch_q, mscratch_d;
  logic [CSR_W-1:0] mepc_q, mepc_d;
  logic [5:0]       mcause_q, mcause_d;
  logic [CSR_W-1:0] mtval_q, mtval_d;
  logic [CSR_W-1:0] mtvec_q, mtvec_d;

  function automatic logic [CSR_W-1:0] irq_word(irq_t irq);
    logic [CSR_W-1:0] w;
    w                         = '0;
    w[IRQ_MSI_BIT]            = irq.software;
    w[IRQ_MTI_BIT]            = irq.timer;
    w[IRQ_MEI_BIT]            = irq.external;
    w[IRQ_MFI_HI:IRQ_MFI_LO]  = irq.fast;
    return w;
  endfunction

  // keep the aligned base, force vectored mode
  function automatic logic [CSR_W-1:0] mtvec_word(logic [CSR_W-1:0] a);
    return {a[CSR_W-1:MTVEC_ALIGN], {(MTVEC_ALIGN-2){1'b0}}, MTVEC_MODE};
  endfunction

  assign mip           = irq_i & mie_q;
  assign irq_pending_o = |mip;

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (csr_addr_i.num)
      CSR_MHARTID: rdata_o = hart_id_i;
      CSR_MSTATUS: begin
        rdata_o[MSTATUS_MIE_BIT]               = mstatus_q.mie;
        rdata_o[MSTATUS_MPIE_BIT]              = mstatus_q.mpie;
        rdata_o[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mstatus_q.mpp;
      end
      CSR_MIE:      rdata_o = irq_word(mie_q);
      CSR_MIP:      rdata_o = irq_word(mip);
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = {mcause_q[5], {(CSR_W-6){1'b0}}, mcause_q[4:0]};
      CSR_MTVAL:    rdata_o = mtval_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      default:      hit_o   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    priv_lvl_d = priv_lvl_q;
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mtvec_d    = mtvec_init_i ? mtvec_word(boot_addr_i) : mtvec_q;

    if (csr_we_i) begin
      case (csr_addr_i.num)
        CSR_MSTATUS: begin
          mstatus_d.mie  = csr_wdata_i[MSTATUS_MIE_BIT];
          mstatus_d.mpie = csr_wdata_i[MSTATUS_MPIE_BIT];
          mstatus_d.mpp  = priv_lvl_e'(csr_wdata_i[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
          if (mstatus_d.mpp != PRIV_LVL_U) begin
            mstatus_d.mpp = PRIV_LVL_M;  // only M and U exist
          end
        end
        CSR_MIE: begin
          mie_d.software = csr_wdata_i[IRQ_MSI_BIT];
          mie_d.timer    = csr_wdata_i[IRQ_MTI_BIT];
          mie_d.external = csr_wdata_i[IRQ_MEI_BIT];
          mie_d.fast     = csr_wdata_i[IRQ_MFI_HI:IRQ_MFI_LO];
        end
        CSR_MSCRATCH: mscratch_d = csr_wdata_i;
        CSR_MEPC:     mepc_d     = {csr_wdata_i[CSR_W-1:1], 1'b0};
        CSR_MCAUSE:   mcause_d   = {csr_wdata_i[CSR_W-1], csr_wdata_i[4:0]};
        CSR_MTVAL:    mtval_d    = csr_wdata_i;
        CSR_MTVEC:    mtvec_d    = mtvec_word(csr_wdata_i);
        default: ;
      endcase
    end

    // controller events override a same-cycle csr write
    if (trap_i.save_cause) begin
      priv_lvl_d     = PRIV_LVL_M;
      mstatus_d.mie  = 1'b0;  // mask interrupts in the handler
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mpp  = priv_lvl_q;
      mepc_d         = trap_i.pc;
      mcause_d       = trap_i.mcause;
      mtval_d        = trap_i.mtval;
    end else if (trap_i.mret) begin
      priv_lvl_d     = mstatus_q.mpp;
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
      mstatus_d.mpp  = PRIV_LVL_U;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_q <= PRIV_LVL_M;
      mstatus_q  <= MSTATUS_RST;
      mie_q      <= '0;
      mcause_q   <= '0;
      mtvec_q    <= {{(CSR_W-2){1'b0}}, MTVEC_MODE};  // reads 1
    end else begin
      priv_lvl_q <= priv_lvl_d;
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mcause_q   <= mcause_d;
      mtvec_q    <= mtvec_d;
    end
  end

  // scratch and trap payload
  always_ff @(posedge clk_i) begin
    mscratch_q <= mscratch_d;
    mepc_q     <= mepc_d;
    mtval_q    <= mtval_d;
  end

  assign priv_lvl_o    = priv_lvl_q;
  assign mstatus_mie_o = mstatus_q.mie;
  assign mepc_o        = mepc_q;
  assign mtvec_o       = mtvec_q;

  trap_mret_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(trap_i.save_cause && trap_i.mret))
    else $error("trap entry and mret in the same cycle");

endmodule

`default_nettype wire

/* tb.f */
+incdir+verif
hw/csr_addr_pkg.sv
hw/csr_regs_pkg.sv
hw/csr_access.sv
hw/csr_trap_regs.sv
hw/csr_perf_counters.sv
hw/csr_top.sv
verif/tb_csr_top.sv

/* verif/csr_ref_model.svh */
/*
 * Reference model of the CSR file: shadow register state,
 * expected read data with the illegal flag, and next-state rules
 */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH
`default_nettype none

// how a read result is compared
localparam logic [1:0] CMP_NONE  = 2'd0;  // only recorded
localparam logic [1:0] CMP_EXACT = 2'd1;
localparam logic [1:0] CMP_GROW  = 2'd2;  // mcycle above last read
localparam logic [1:0] CMP_HOLD  = 2'd3;  // mcycle equal to last read

typedef struct packed {
  priv_lvl_e        priv;
  mstatus_t         mstatus;
  irq_t             mie;
  irq_t             irq;
  logic [CSR_W-1:0] mscratch;
  logic [CSR_W-1:0] mepc;
  logic             mepc_ok;   // mepc has been loaded
  logic [5:0]       mcause;
  logic [CSR_W-1:0] mtval;
  logic [CSR_W-1:0] mtvec;
  logic [CSR_W-1:0] hart;
  logic [63:0]      minstret;
  logic [HPM_W-1:0] hpm3;
  logic [HPM_W-1:0] hpm4;
  logic [4:0]       inhibit;
  logic             cyc_seen;  // a reference mcycle value exists
} shadow_t;

typedef struct packed {
  logic [CSR_W-1:0] data;
  logic             illegal;
  logic [1:0]       kind;
} exp_t;

// mie and mip layout
function automatic logic [CSR_W-1:0] irq_bits(irq_t q);
  return {1'b0, q.fast, 4'b0, q.external, 3'b0, q.timer, 3'b0, q.software, 3'b0};
endfunction

function automatic shadow_t reset_shadow(logic [CSR_W-1:0] hart);
  shadow_t s;
  s         = '0;
  s.priv    = PRIV_LVL_M;
  s.mstatus = MSTATUS_RST;
  s.mtvec   = 32'h0000_0001;
  s.hart    = hart;
  return s;
endfunction

function automatic exp_t expected_read(shadow_t s, logic [11:0] a, csr_op_e op,
                                       priv_lvl_e p);
  exp_t e;
  logic hit;
  e      = '0;
  e.kind = CMP_EXACT;
  hit    = 1'b1;
  case (a)
    CSR_MSTATUS: e.data = {19'b0, s.mstatus.mpp, 3'b0, s.mstatus.mpie, 3'b0,
                           s.mstatus.mie, 3'b0};
    CSR_MIE:           e.data = irq_bits(s.mie);
    CSR_MIP:           e.data = irq_bits(irq_t'(s.irq & s.mie));
    CSR_MSCRATCH:      e.data = s.mscratch;
    CSR_MEPC:          e.data = s.mepc;
    CSR_MCAUSE:        e.data = {s.mcause[5], 26'b0, s.mcause[4:0]};
    CSR_MTVAL:         e.data = s.mtval;
    CSR_MTVEC:         e.data = s.mtvec;
    CSR_MHARTID:       e.data = s.hart;
    CSR_MCOUNTINHIBIT: e.data = {27'b0, s.inhibit};
    CSR_MCYCLE:        e.kind = !s.cyc_seen ? CMP_NONE : (s.inhibit[0] ? CMP_HOLD : CMP_GROW);
    CSR_MCYCLEH:       e.kind = CMP_NONE;
    CSR_MINSTRET:      e.data = s.minstret[31:0];
    CSR_MINSTRETH:     e.data = s.minstret[63:32];
    CSR_MHPMCOUNTER3:  e.data = s.hpm3[31:0];
    CSR_MHPMCOUNTER3H: e.data = {24'b0, s.hpm3[HPM_W-1:32]};
    CSR_MHPMCOUNTER4:  e.data = s.hpm4[31:0];
    CSR_MHPMCOUNTER4H: e.data = {24'b0, s.hpm4[HPM_W-1:32]};
    default:           hit    = 1'b0;
  endcase
  e.illegal = !hit || (a[9:8] > p) || ((a[11:10] == 2'b11) && (op != CSR_OP_READ));
  if (e.illegal) begin
    e.kind = CMP_NONE;
  end
  return e;
endfunction

function automatic shadow_t model_next(shadow_t s, csr_req_t r, exp_t e, trap_ev_t t,
                                       perf_ev_t pf, logic init, logic [CSR_W-1:0] boot);
  shadow_t          n;
  logic [CSR_W-1:0] w;
  logic [11:0]      a;
  logic             we;
  n  = s;
  a  = r.addr;
  we = r.access && (r.op != CSR_OP_READ) && !e.illegal;
  case (r.op)
    CSR_OP_SET:   w = r.wdata | e.data;
    CSR_OP_CLEAR: w = ~r.wdata & e.data;
    default:      w = r.wdata;
  endcase
  if (init) n.mtvec = {boot[31:8], 8'h01};
  if (r.access && !e.illegal && (a == CSR_MCYCLE)) n.cyc_seen = 1'b1;
  // counting comes first so a write of the same cycle replaces it
  if (pf.instr_ret && !s.inhibit[2]) n.minstret = s.minstret + 64'd1;
  if (pf.load && !s.inhibit[3]) n.hpm3 = s.hpm3 + 40'd1;
  if (pf.store && !s.inhibit[4]) n.hpm4 = s.hpm4 + 40'd1;
  if (we) begin
    case (a)
      CSR_MSTATUS: begin
        n.mstatus.mie  = w[3];
        n.mstatus.mpie = w[7];
        n.mstatus.mpp  = (w[12:11] == 2'b00) ? PRIV_LVL_U : PRIV_LVL_M;
      end
      CSR_MIE:      n.mie = irq_t'({w[3], w[7], w[11], w[30:16]});
      CSR_MSCRATCH: n.mscratch = w;
      CSR_MEPC: begin
        n.mepc    = {w[31:1], 1'b0};
        n.mepc_ok = 1'b1;
      end
      CSR_MCAUSE: n.mcause = {w[31], w[4:0]};
      CSR_MTVAL:  n.mtval  = w;
      CSR_MTVEC:  n.mtvec  = {w[31:8], 8'h01};
      CSR_MCOUNTINHIBIT: begin
        n.inhibit  = {w[4:2], 1'b0, w[0]};
        n.cyc_seen = 1'b0;  // new reference value needed
      end
      CSR_MINSTRET:      n.minstret = {s.minstret[63:32], w};
      CSR_MINSTRETH:     n.minstret = {w, s.minstret[31:0]};
      CSR_MHPMCOUNTER3:  n.hpm3     = {s.hpm3[HPM_W-1:32], w};
      CSR_MHPMCOUNTER3H: n.hpm3     = {w[7:0], s.hpm3[31:0]};
      CSR_MHPMCOUNTER4:  n.hpm4     = {s.hpm4[HPM_W-1:32], w};
      CSR_MHPMCOUNTER4H: n.hpm4     = {w[7:0], s.hpm4[31:0]};
      default: ;
    endcase
  end
  if (t.save_cause) begin
    n.priv         = PRIV_LVL_M;
    n.mstatus.mie  = 1'b0;
    n.mstatus.mpie = s.mstatus.mie;
    n.mstatus.mpp  = s.priv;
    n.mepc         = t.pc;
    n.mepc_ok      = 1'b1;
    n.mcause       = t.mcause;
    n.mtval        = t.mtval;
  end else if (t.mret) begin
    n.priv         = s.mstatus.mpp;
    n.mstatus.mie  = s.mstatus.mpie;
    n.mstatus.mpie = 1'b1;
    n.mstatus.mpp  = PRIV_LVL_U;
  end
  return n;
endfunction

`default_nettype wire
`endif

/* verif/tb_csr_top.sv */
/*
 * Testbench for the CSR file: clock and reset, falling-edge stimulus,
 * rising-edge compare process, typed compare tasks and watchdog
 */
`default_nettype none

module tb_csr_top;
  timeunit 1ns;
  timeprecision 1ps;

  import csr_addr_pkg::*;
  import csr_regs_pkg::*;

  `include "csr_ref_model.svh"

  localparam int unsigned CLK_PERIOD  = 20;
  localparam int unsigned TEST_CYCLES = 200;  // covers all test steps
  localparam logic [11:0] RW_CSRS [4] = '{CSR_MSCRATCH, CSR_MIE, CSR_MTVEC, CSR_MEPC};

  logic             clk_i;
  logic             rst_ni;
  csr_req_t         csr_req;
  irq_t             irq_lines;
  trap_ev_t         trap_ev;
  perf_ev_t         perf_ev;
  logic [CSR_W-1:0] hart_id;
  logic [CSR_W-1:0] boot_addr;
  logic             mtvec_init;
  logic [CSR_W-1:0] csr_rdata;
  logic             illegal;
  logic             irq_pending;
  logic             mstatus_mie;
  logic [CSR_W-1:0] mepc;
  logic [CSR_W-1:0] mtvec;
  priv_lvl_e        priv_lvl;

  // inputs staged for the next falling edge
  csr_req_t         nxt_req;
  trap_ev_t         nxt_trap;
  perf_ev_t         nxt_perf;
  irq_t             nxt_irq;
  logic             nxt_init;

  shadow_t          shadow;
  shadow_t          shadow_nxt;
  exp_t             exp_rd;
  logic             exp_valid;
  logic [CSR_W-1:0] last_cycle;
  int unsigned      err_count;

  csr_top csr_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_req_i     (csr_req),
    .irq_i         (irq_lines),
    .trap_i        (trap_ev),
    .perf_i        (perf_ev),
    .hart_id_i     (hart_id),
    .boot_addr_i   (boot_addr),
    .mtvec_init_i  (mtvec_init),
    .csr_rdata_o   (csr_rdata),
    .illegal_o     (illegal),
    .irq_pending_o (irq_pending),
    .mstatus_mie_o (mstatus_mie),
    .mepc_o        (mepc),
    .mtvec_o       (mtvec),
    .priv_lvl_o    (priv_lvl)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string why);
    err_count++;
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input logic [CSR_W-1:0] act, input logic [CSR_W-1:0] exp,
                            input string what);
    if (act !== exp) begin
      fail_now($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      fail_now($sformatf("mismatch at %0t ns: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_priv(input priv_lvl_e act, input priv_lvl_e exp, input string what);
    if (act !== exp) begin
      fail_now($sformatf("mismatch at %0t ns: %s is %s, expected %s", $time, what,
                         act.name(), exp.name()));
    end
  endtask

  // outputs are sampled before the edge updates any register
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_bit(illegal, exp_valid && exp_rd.illegal, "illegal_o");  // low without access
      if (exp_valid) begin
        case (exp_rd.kind)
          CMP_EXACT: check_word(csr_rdata, exp_rd.data, "csr_rdata_o");
          CMP_GROW:  check_bit(csr_rdata > last_cycle, 1'b1, "mcycle growth");
          CMP_HOLD:  check_word(csr_rdata, last_cycle, "mcycle while inhibited");
          default: ;
        endcase
        if (!exp_rd.illegal && (csr_req.addr.num == CSR_MCYCLE)) begin
          last_cycle = csr_rdata;
        end
      end
      check_priv(priv_lvl, shadow.priv, "priv_lvl_o");
      check_bit(irq_pending, |(shadow.irq & shadow.mie), "irq_pending_o");
      check_bit(mstatus_mie, shadow.mstatus.mie, "mstatus_mie_o");
      check_word(mtvec, shadow.mtvec, "mtvec_o");
      if (shadow.mepc_ok) check_word(mepc, shadow.mepc, "mepc_o");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // one cycle: commit the model, drive staged inputs, predict
  task automatic tick();
    @(negedge clk_i);
    shadow     = shadow_nxt;
    csr_req    = nxt_req;
    trap_ev    = nxt_trap;
    perf_ev    = nxt_perf;
    irq_lines  = nxt_irq;
    mtvec_init = nxt_init;
    shadow.irq = nxt_irq;
    exp_rd     = expected_read(shadow, nxt_req.addr, nxt_req.op, shadow.priv);
    exp_valid  = nxt_req.access;
    shadow_nxt = model_next(shadow, nxt_req, exp_rd, nxt_trap, nxt_perf, nxt_init, boot_addr);
    nxt_req.access = 1'b0;  // strobes last a single cycle
    nxt_trap       = '0;
    nxt_perf       = '0;
    nxt_init       = 1'b0;
  endtask

  task automatic csr_do(input csr_op_e op, input logic [11:0] addr,
                        input logic [CSR_W-1:0] wdata);
    nxt_req.access = 1'b1;
    nxt_req.addr   = addr;
    nxt_req.op     = op;
    nxt_req.wdata  = wdata;
    tick();
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) tick();
  endtask

  task automatic trap_entry(input logic [5:0] cause);
    nxt_trap.save_cause = 1'b1;
    nxt_trap.pc         = $urandom();
    nxt_trap.mcause     = cause;
    nxt_trap.mtval      = $urandom();
  endtask

  initial begin
    logic [CSR_W-1:0] r;
    int unsigned      n;
    void'($urandom(32'h38c00460));
    rst_ni     = 1'b0;
    csr_req    = '0;
    irq_lines  = '0;
    trap_ev    = '0;
    perf_ev    = '0;
    hart_id    = $urandom();
    boot_addr  = '0;
    mtvec_init = 1'b0;
    nxt_req    = '0;
    nxt_trap   = '0;
    nxt_perf   = '0;
    nxt_irq    = '0;
    nxt_init   = 1'b0;
    exp_valid  = 1'b0;
    exp_rd     = '0;
    last_cycle = '0;
    err_count  = 0;
    shadow     = reset_shadow(hart_id);
    shadow_nxt = shadow;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // read, write, set and clear with masking
    for (int i = 0; i < 4; i++) begin
      csr_do(CSR_OP_WRITE, RW_CSRS[i], $urandom());
      csr_do(CSR_OP_READ, RW_CSRS[i], '0);
      csr_do(CSR_OP_SET, RW_CSRS[i], $urandom());
      csr_do(CSR_OP_CLEAR, RW_CSRS[i], $urandom());
      csr_do(CSR_OP_READ, RW_CSRS[i], '0);
    end
    csr_do(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_1080);  // mpp 2'b10 folds to M
    csr_do(CSR_OP_READ, CSR_MSTATUS, '0);
    boot_addr = $urandom();
    nxt_init  = 1'b1;
    tick();
    csr_do(CSR_OP_READ, CSR_MTVEC, '0);

    // illegal accesses
    csr_do(CSR_OP_READ, 12'h7c0, '0);
    csr_do(CSR_OP_WRITE, 12'h3a0, $urandom());
    csr_do(CSR_OP_WRITE, CSR_MHARTID, $urandom());
    csr_do(CSR_OP_CLEAR, CSR_MHARTID, '1);
    csr_do(CSR_OP_READ, CSR_MHARTID, '0);

    // mip follows the lines masked by mie
    csr_do(CSR_OP_WRITE, CSR_MIE, '1);
    for (int i = 0; i < 8; i++) begin
      r       = $urandom();
      nxt_irq = r[17:0];
      if (i == 4) csr_do(CSR_OP_WRITE, CSR_MIE, $urandom());
      csr_do(CSR_OP_READ, CSR_MIP, '0);
    end
    nxt_irq = '0;

    // trap entry, mret to U, trap back to M
    csr_do(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008);
    trap_entry(6'h0b);
    tick();
    csr_do(CSR_OP_READ, CSR_MEPC, '0);
    csr_do(CSR_OP_READ, CSR_MCAUSE, '0);
    csr_do(CSR_OP_READ, CSR_MTVAL, '0);
    csr_do(CSR_OP_READ, CSR_MSTATUS, '0);
    csr_do(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0080);  // mpp back to U
    nxt_trap.mret = 1'b1;
    tick();
    csr_do(CSR_OP_READ, CSR_MSTATUS, '0);
    csr_do(CSR_OP_WRITE, CSR_MSCRATCH, $urandom());
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    trap_entry(6'h27);
    tick();
    csr_do(CSR_OP_READ, CSR_MSTATUS, '0);
    csr_do(CSR_OP_READ, CSR_MSCRATCH, '0);
    trap_entry(6'h02);
    csr_do(CSR_OP_WRITE, CSR_MEPC, $urandom());  // trap has priority
    csr_do(CSR_OP_READ, CSR_MEPC, '0);

    // counters
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    idle(3);
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    csr_do(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0000_0001);
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    idle(3);
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    csr_do(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '1);
    csr_do(CSR_OP_READ, CSR_MCOUNTINHIBIT, '0);
    csr_do(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    idle(2);
    csr_do(CSR_OP_READ, CSR_MCYCLE, '0);
    nxt_perf.instr_ret = 1'b1;  // write replaces this count
    csr_do(CSR_OP_WRITE, CSR_MINSTRET, $urandom());
    csr_do(CSR_OP_WRITE, CSR_MINSTRETH, $urandom());
    n = ($urandom() % 8) + 1;
    repeat (n) begin
      nxt_perf.instr_ret = 1'b1;
      tick();
    end
    csr_do(CSR_OP_READ, CSR_MINSTRET, '0);
    csr_do(CSR_OP_READ, CSR_MINSTRETH, '0);
    csr_do(CSR_OP_WRITE, CSR_MHPMCOUNTER3H, '1);
    csr_do(CSR_OP_WRITE, CSR_MHPMCOUNTER3, 32'hffff_fffe);
    repeat (3) begin
      nxt_perf.load = 1'b1;
      tick();
    end
    csr_do(CSR_OP_READ, CSR_MHPMCOUNTER3, '0);
    csr_do(CSR_OP_READ, CSR_MHPMCOUNTER3H, '0);
    repeat (n) begin
      nxt_perf.store = 1'b1;
      tick();
    end
    csr_do(CSR_OP_READ, CSR_MHPMCOUNTER4, '0);
    csr_do(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0000_0010);
    repeat (3) begin
      nxt_perf.store = 1'b1;
      tick();
    end
    csr_do(CSR_OP_READ, CSR_MHPMCOUNTER4, '0);
    csr_do(CSR_OP_READ, CSR_MHPMCOUNTER4H, '0);
    idle(2);

    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TEST_CYCLES * CLK_PERIOD + 1000);
    fail_now("simulation did not finish within the time limit");
  end

endmodule

`default_nettype wire
